// ==== include/video_params.svh ====
`ifndef VIDEO_PARAMS_SVH
`define VIDEO_PARAMS_SVH

// raster coordinate and memory widths
`define VIDEO_COORD_W 10
`define VIDEO_RAM_AW 12

// osd text geometry
`define TEXT_COLS 40
`define TEXT_AW 10

// font, indexed by low bits of the char code
`define FONT_ROWS 8
`define FONT_GLYPHS 4

// position to output, in clocks
`define VIDEO_LATENCY 4

`endif

// ==== verilog/video_pkg.sv ====
`include "video_params.svh"

package video_pkg;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } pixel_t;

    typedef struct packed {
        logic [`VIDEO_COORD_W-1:0] h_total;
        logic [`VIDEO_COORD_W-1:0] h_visible;
        logic [`VIDEO_COORD_W-1:0] h_sync_start;
        logic [`VIDEO_COORD_W-1:0] h_sync_width;
        logic [`VIDEO_COORD_W-1:0] v_total;
        logic [`VIDEO_COORD_W-1:0] v_visible;
        logic [`VIDEO_COORD_W-1:0] v_sync_start;
        logic [`VIDEO_COORD_W-1:0] v_sync_width;
        logic                      h_sync_pol;
        logic                      v_sync_pol;
        // pixel repeat factors, never 0
        logic [3:0]                rep_h;
        logic [3:0]                rep_v;
        logic [`VIDEO_RAM_AW-1:0]  line_length;
        logic                      osd_enable;
        logic [`VIDEO_COORD_W-1:0] osd_bg_x_start;
        logic [`VIDEO_COORD_W-1:0] osd_bg_x_end;
        logic [`VIDEO_COORD_W-1:0] osd_bg_y_start;
        logic [`VIDEO_COORD_W-1:0] osd_bg_y_end;
        logic [`VIDEO_COORD_W-1:0] osd_text_x_start;
        logic [`VIDEO_COORD_W-1:0] osd_text_y_start;
        logic [`VIDEO_COORD_W-1:0] osd_text_x_end;
        logic [`VIDEO_COORD_W-1:0] osd_text_y_end;
        logic [7:0]                highlight_row;
    } video_config_t;

    typedef struct packed {
        logic       active;
        logic       odd_even;
        logic [7:0] intensity;
    } scanline_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic draw_area;
    } sync_t;

    typedef struct packed {
        logic in_bg;
        logic in_text;
        logic highlight;
    } overlay_t;

endpackage

// ==== verilog/delay_line.sv ====
`timescale 1ns/10ps

module delay_line #(
    parameter int CYCLES = 1,
    parameter int WIDTH = 1
) (
    input  logic             clock,
    input  logic             reset,
    input  logic [WIDTH-1:0] init,
    input  logic [WIDTH-1:0] in,
    output logic [WIDTH-1:0] out
);

    logic [WIDTH-1:0] stage [CYCLES];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < CYCLES; i++) begin
                stage[i] <= init;
            end
        end else begin
            stage[0] <= in;
            for (int i = 1; i < CYCLES; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign out = stage[CYCLES-1];

endmodule

// ==== verilog/char_rom.sv ====
`timescale 1ns/10ps
`include "video_params.svh"

module char_rom (
    input  logic       clock,
    input  logic [1:0] code,
    input  logic [2:0] row,
    output logic [7:0] bits
);

    localparam int DEPTH = `FONT_GLYPHS * `FONT_ROWS;

    // one byte per glyph row, msb is the leftmost pixel
    logic [7:0] rom [DEPTH];

    initial begin
        $readmemh("font.hex", rom);
    end

    always_ff @(posedge clock) begin
        bits <= rom[{code, row}];
    end

endmodule

// ==== verilog/raster_timing.sv ====
`timescale 1ns/10ps
`include "video_params.svh"

module raster_timing
    import video_pkg::*;
(
    input  logic                     clock,
    input  logic                     reset,
    input  video_config_t            cfg,
    input  scanline_t                scan,
    input  logic                     start_req,
    output logic                     start_ack,
    output logic [`VIDEO_RAM_AW-1:0] ram_addr,
    output logic [`TEXT_AW-1:0]      text_addr,
    output sync_t                    sync,
    output overlay_t                 overlay,
    output logic                     is_scanline,
    output logic [2:0]               glyph_col,
    output logic [2:0]               glyph_row
);

    localparam int CW = `VIDEO_COORD_W;
    localparam int AW = `VIDEO_RAM_AW;
    localparam int TAW = `TEXT_AW;

    logic          running;
    logic [CW-1:0] x;
    logic [CW-1:0] y;
    logic [3:0]    rep_cnt_h;
    logic [3:0]    rep_cnt_v;
    logic [AW-1:0] addr_x;
    logic [AW-1:0] line_base;

    logic          last_x;
    logic          last_y;
    logic          draw;
    logic [CW:0]   h_sync_end;
    logic [CW:0]   v_sync_end;
    logic          hs_on;
    logic          vs_on;
    logic          in_bg;
    logic          in_text;
    logic [CW-1:0] text_dx;
    logic [CW-1:0] text_dy;
    logic [CW-1:0] text_row;
    logic [CW-1:0] text_col;
    logic [2:0]    glyph_row_q;

    ////////////////////////////////////////////////////////////
    // per-position decode

    always_comb begin
        last_x = (x == cfg.h_total - 1'b1);
        last_y = (y == cfg.v_total - 1'b1);
        draw = running && (x < cfg.h_visible) && (y < cfg.v_visible);

        h_sync_end = {1'b0, cfg.h_sync_start} + {1'b0, cfg.h_sync_width};
        v_sync_end = {1'b0, cfg.v_sync_start} + {1'b0, cfg.v_sync_width};
        hs_on = running && (x >= cfg.h_sync_start) && ({1'b0, x} < h_sync_end);
        vs_on = running && (y >= cfg.v_sync_start) && ({1'b0, y} < v_sync_end);

        in_bg = (x >= cfg.osd_bg_x_start) && (x < cfg.osd_bg_x_end)
            && (y >= cfg.osd_bg_y_start) && (y < cfg.osd_bg_y_end);
        in_text = (x >= cfg.osd_text_x_start) && (x < cfg.osd_text_x_end)
            && (y >= cfg.osd_text_y_start) && (y < cfg.osd_text_y_end);

        // cell position inside the text window
        text_dx = x - cfg.osd_text_x_start;
        text_dy = y - cfg.osd_text_y_start;
        text_row = CW'(text_dy / `FONT_ROWS);
        text_col = text_dx >> 3;
    end

    ////////////////////////////////////////////////////////////
    // start handshake and raster walk

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            running <= 1'b0;
            start_ack <= 1'b0;
            x <= '0;
            y <= '0;
            rep_cnt_h <= '0;
            rep_cnt_v <= '0;
            addr_x <= '0;
            line_base <= '0;
        end else begin
            if (!running && start_req) begin
                start_ack <= 1'b1;
            end else if (!start_req) begin
                start_ack <= 1'b0;
            end

            if (!running) begin
                if (start_req) begin
                    running <= 1'b1;
                    x <= '0;
                    y <= '0;
                    rep_cnt_h <= '0;
                    rep_cnt_v <= '0;
                    addr_x <= '0;
                    line_base <= '0;
                end
            end else if (last_x) begin
                x <= '0;
                rep_cnt_h <= '0;
                addr_x <= '0;
                if (last_y) begin
                    y <= '0;
                    rep_cnt_v <= '0;
                    line_base <= '0;
                end else begin
                    y <= y + 1'b1;
                    // next stored line after rep_v output lines
                    if (rep_cnt_v == cfg.rep_v - 1'b1) begin
                        rep_cnt_v <= '0;
                        line_base <= line_base + cfg.line_length;
                    end else begin
                        rep_cnt_v <= rep_cnt_v + 1'b1;
                    end
                end
            end else begin
                x <= x + 1'b1;
                if (rep_cnt_h == cfg.rep_h - 1'b1) begin
                    rep_cnt_h <= '0;
                    addr_x <= addr_x + 1'b1;
                end else begin
                    rep_cnt_h <= rep_cnt_h + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // registered addresses and flags, one clock after position

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ram_addr <= '0;
            text_addr <= '0;
            sync <= '{hsync: ~cfg.h_sync_pol, vsync: ~cfg.v_sync_pol, draw_area: 1'b0};
            overlay <= '0;
            is_scanline <= 1'b0;
        end else begin
            ram_addr <= draw ? line_base + addr_x : '0;
            text_addr <= in_text ? TAW'(text_row * `TEXT_COLS + text_col) : '0;
            sync.hsync <= hs_on ? cfg.h_sync_pol : ~cfg.h_sync_pol;
            sync.vsync <= vs_on ? cfg.v_sync_pol : ~cfg.v_sync_pol;
            sync.draw_area <= draw;
            overlay.in_bg <= in_bg;
            overlay.in_text <= in_text;
            overlay.highlight <= (text_row == CW'(cfg.highlight_row));
            is_scanline <= scan.active && (y[0] == scan.odd_even);
        end
    end

    // glyph row must meet the text ram data at the rom input
    always_ff @(posedge clock) begin
        glyph_col <= text_dx[2:0];
        glyph_row_q <= text_dy[2:0];
        glyph_row <= glyph_row_q;
    end

endmodule

// ==== verilog/pixel_mixer.sv ====
`timescale 1ns/10ps

module pixel_mixer
    import video_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  video_config_t cfg,
    input  scanline_t     scan,
    input  pixel_t        ram_pixel,
    input  logic [7:0]    glyph_bits,
    input  logic [2:0]    glyph_col,
    input  overlay_t      overlay,
    input  logic          is_scanline,
    input  sync_t         sync_in,
    output pixel_t        video_out,
    output sync_t         sync_out
);

    logic   glyph_on;
    pixel_t base;
    pixel_t mixed;

    function automatic logic [7:0] dim(input logic [7:0] chan, input logic [7:0] level);
        logic [15:0] prod;
        prod = chan * level;
        return prod[15:8];
    endfunction

    always_comb begin
        // highlighted row shows inverted glyphs
        glyph_on = glyph_bits[3'd7 - glyph_col] ^ overlay.highlight;

        if (!sync_in.draw_area) begin
            base = '0;
        end else if (cfg.osd_enable && overlay.in_text) begin
            base = glyph_on ? '{8'hff, 8'hff, 8'hff} : '0;
        end else if (cfg.osd_enable && overlay.in_bg) begin
            base = '{ram_pixel.red >> 1, ram_pixel.green >> 1, ram_pixel.blue >> 1};
        end else begin
            base = ram_pixel;
        end

        mixed = base;
        if (is_scanline) begin
            mixed.red = dim(base.red, scan.intensity);
            mixed.green = dim(base.green, scan.intensity);
            mixed.blue = dim(base.blue, scan.intensity);
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            video_out <= '0;
            sync_out <= '{hsync: ~cfg.h_sync_pol, vsync: ~cfg.v_sync_pol, draw_area: 1'b0};
        end else begin
            video_out <= mixed;
            sync_out <= sync_in;
        end
    end

endmodule

// ==== verilog/video_out_top.sv ====
`timescale 1ns/10ps
`include "video_params.svh"

module video_out_top
    import video_pkg::*;
(
    input  logic                     clock,
    input  logic                     reset,
    input  video_config_t            cfg,
    input  scanline_t                scan,
    input  logic                     start_req,
    input  pixel_t                   ram_data,
    input  logic [7:0]               text_data,
    output logic                     start_ack,
    output logic [`VIDEO_RAM_AW-1:0] ram_addr,
    output logic [`TEXT_AW-1:0]      text_addr,
    output pixel_t                   video_out,
    output logic                     hsync,
    output logic                     vsync,
    output logic                     draw_area
);

    // t1 is the address stage, t3 the mixer input
    sync_t      sync_t1;
    sync_t      sync_t3;
    overlay_t   overlay_t1;
    overlay_t   overlay_t3;
    logic       scanline_t1;
    logic       scanline_t3;
    logic [2:0] glyph_col_t1;
    logic [2:0] glyph_col_t3;
    logic [2:0] glyph_row_t2;
    logic [7:0] glyph_bits_t3;
    pixel_t     ram_pixel_t3;

    raster_timing u_timing (
        .clock       (clock),
        .reset       (reset),
        .cfg         (cfg),
        .scan        (scan),
        .start_req   (start_req),
        .start_ack   (start_ack),
        .ram_addr    (ram_addr),
        .text_addr   (text_addr),
        .sync        (sync_t1),
        .overlay     (overlay_t1),
        .is_scanline (scanline_t1),
        .glyph_col   (glyph_col_t1),
        .glyph_row   (glyph_row_t2)
    );

    char_rom u_font (
        .clock (clock),
        .code  (text_data[1:0]),
        .row   (glyph_row_t2),
        .bits  (glyph_bits_t3)
    );

    ////////////////////////////////////////////////////////////
    // alignment to the mixer input

    delay_line #(
        .CYCLES (`VIDEO_LATENCY - 2),
        .WIDTH  ($bits(sync_t))
    ) u_sync_delay (
        .clock (clock),
        .reset (reset),
        .init  ({~cfg.h_sync_pol, ~cfg.v_sync_pol, 1'b0}),
        .in    (sync_t1),
        .out   (sync_t3)
    );

    delay_line #(
        .CYCLES (`VIDEO_LATENCY - 2),
        .WIDTH  ($bits(overlay_t) + 4)
    ) u_side_delay (
        .clock (clock),
        .reset (reset),
        .init  ('0),
        .in    ({overlay_t1, scanline_t1, glyph_col_t1}),
        .out   ({overlay_t3, scanline_t3, glyph_col_t3})
    );

    // ram data lands one clock ahead of the glyph
    delay_line #(
        .CYCLES (`VIDEO_LATENCY - 3),
        .WIDTH  ($bits(pixel_t))
    ) u_pixel_delay (
        .clock (clock),
        .reset (reset),
        .init  ('0),
        .in    (ram_data),
        .out   (ram_pixel_t3)
    );

    pixel_mixer u_mixer (
        .clock       (clock),
        .reset       (reset),
        .cfg         (cfg),
        .scan        (scan),
        .ram_pixel   (ram_pixel_t3),
        .glyph_bits  (glyph_bits_t3),
        .glyph_col   (glyph_col_t3),
        .overlay     (overlay_t3),
        .is_scanline (scanline_t3),
        .sync_in     (sync_t3),
        .video_out   (video_out),
        .sync_out    ({hsync, vsync, draw_area})
    );

endmodule

// ==== dv/video_checker.sv ====
`timescale 1ns/10ps

module video_checker
    import video_pkg::*;
(
    input logic          clock,
    input logic          reset,
    input video_config_t cfg,
    input logic          start_req,
    input logic          start_ack,
    input logic          hsync,
    input logic          vsync
);

    int assert_fails = 0;

    // four-phase start handshake
    ack_rise: assert property (@(posedge clock) disable iff (reset)
        $rose(start_ack) |-> $past(start_req))
    else begin
        $error("start_ack rose while start_req was low");
        assert_fails++;
    end

    ack_fall: assert property (@(posedge clock) disable iff (reset)
        $fell(start_ack) |-> !$past(start_req))
    else begin
        $error("start_ack fell while start_req was still high");
        assert_fails++;
    end

    // syncs sit at the inactive level through reset
    reset_sync: assert property (@(posedge clock)
        reset && $past(reset) |-> hsync == !cfg.h_sync_pol && vsync == !cfg.v_sync_pol)
    else begin
        $error("hsync or vsync active during reset");
        assert_fails++;
    end

endmodule

// ==== dv/video_monitor.sv ====
`timescale 1ns/10ps
`include "video_params.svh"

module video_monitor
    import video_pkg::*;
(
    input  logic                     clock,
    input  logic                     reset,
    input  video_config_t            cfg,
    input  scanline_t                scan,
    input  logic                     start_ack,
    input  logic [`VIDEO_RAM_AW-1:0] ram_addr,
    input  logic [`TEXT_AW-1:0]      text_addr,
    input  pixel_t                   video_out,
    input  logic                     hsync,
    input  logic                     vsync,
    input  logic                     draw_area,
    output int                       checks,
    output int                       errors
);

    localparam int LAT = `VIDEO_LATENCY;

    logic [7:0] font [`FONT_GLYPHS * `FONT_ROWS];

    logic   tracking;
    int     pos_x;
    int     pos_y;
    // predictions for the positions still in flight, newest first
    pixel_t exp_pix [LAT];
    sync_t  exp_sync [LAT];
    int     exp_x [LAT];
    int     exp_y [LAT];

    initial begin
        $readmemh("font.hex", font);
        tracking = 1'b0;
        checks = 0;
        errors = 0;
    end

    function automatic sync_t idle_sync();
        sync_t s;
        s.hsync = !cfg.h_sync_pol;
        s.vsync = !cfg.v_sync_pol;
        s.draw_area = 1'b0;
        return s;
    endfunction

    task automatic predict(input int px, input int py, output pixel_t pix, output sync_t sy);
        int   addr;
        int   dx;
        int   dy;
        int   code;
        logic in_text;
        logic in_bg;
        logic bit_on;
        sy.draw_area = (px < cfg.h_visible) && (py < cfg.v_visible);
        sy.hsync = (px >= cfg.h_sync_start && px < cfg.h_sync_start + cfg.h_sync_width)
            ? cfg.h_sync_pol : !cfg.h_sync_pol;
        sy.vsync = (py >= cfg.v_sync_start && py < cfg.v_sync_start + cfg.v_sync_width)
            ? cfg.v_sync_pol : !cfg.v_sync_pol;

        // stored pixel at the repeat-scaled address
        addr = (py / cfg.rep_v) * cfg.line_length + px / cfg.rep_h;
        pix.red = addr[7:0];
        pix.green = addr[11:4];
        pix.blue = ~addr[7:0];

        in_bg = px >= cfg.osd_bg_x_start && px < cfg.osd_bg_x_end
            && py >= cfg.osd_bg_y_start && py < cfg.osd_bg_y_end;
        in_text = px >= cfg.osd_text_x_start && px < cfg.osd_text_x_end
            && py >= cfg.osd_text_y_start && py < cfg.osd_text_y_end;

        if (!sy.draw_area) begin
            pix = '0;
        end else if (cfg.osd_enable && in_text) begin
            dx = px - int'(cfg.osd_text_x_start);
            dy = py - int'(cfg.osd_text_y_start);
            code = ((dy / `FONT_ROWS) * `TEXT_COLS + dx / 8) % 4;
            bit_on = font[code * `FONT_ROWS + dy % `FONT_ROWS][7 - dx % 8];
            // highlighted text row is drawn inverted
            if (dy / `FONT_ROWS == int'(cfg.highlight_row)) begin
                bit_on = !bit_on;
            end
            pix = bit_on ? 24'hffffff : 24'h000000;
        end else if (cfg.osd_enable && in_bg) begin
            pix.red = pix.red >> 1;
            pix.green = pix.green >> 1;
            pix.blue = pix.blue >> 1;
        end

        if (scan.active && (py % 2) == int'(scan.odd_even)) begin
            pix.red = 8'((int'(pix.red) * int'(scan.intensity)) >> 8);
            pix.green = 8'((int'(pix.green) * int'(scan.intensity)) >> 8);
            pix.blue = 8'((int'(pix.blue) * int'(scan.intensity)) >> 8);
        end
    endtask

    task automatic compare(input pixel_t pix, input sync_t sy, input int px, input int py);
        checks++;
        if (hsync !== sy.hsync) begin
            errors++;
            $display("mismatch hsync at x %0d y %0d: got %h expected %h", px, py, hsync, sy.hsync);
        end
        if (vsync !== sy.vsync) begin
            errors++;
            $display("mismatch vsync at x %0d y %0d: got %h expected %h", px, py, vsync, sy.vsync);
        end
        if (draw_area !== sy.draw_area) begin
            errors++;
            $display("mismatch draw_area at x %0d y %0d: got %h expected %h",
                px, py, draw_area, sy.draw_area);
        end
        if (video_out !== pix) begin
            errors++;
            $display("mismatch video_out at x %0d y %0d: got %h expected %h",
                px, py, video_out, pix);
        end
    endtask

    // addresses are registered one clock after their position
    task automatic compare_addr(input int px, input int py);
        int ram_exp;
        int text_exp;
        int dx;
        int dy;
        ram_exp = 0;
        if (px < cfg.h_visible && py < cfg.v_visible) begin
            ram_exp = (py / cfg.rep_v) * cfg.line_length + px / cfg.rep_h;
        end
        if (ram_addr !== ram_exp) begin
            errors++;
            $display("mismatch ram_addr at x %0d y %0d: got %h expected %h",
                px, py, ram_addr, ram_exp);
        end
        // text address only defined inside the text window
        if (px >= cfg.osd_text_x_start && px < cfg.osd_text_x_end
            && py >= cfg.osd_text_y_start && py < cfg.osd_text_y_end) begin
            dx = px - int'(cfg.osd_text_x_start);
            dy = py - int'(cfg.osd_text_y_start);
            text_exp = (dy / `FONT_ROWS) * `TEXT_COLS + dx / 8;
            if (text_addr !== text_exp) begin
                errors++;
                $display("mismatch text_addr at x %0d y %0d: got %h expected %h",
                    px, py, text_addr, text_exp);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // sampled on the falling edge, away from the dut updates

    always @(negedge clock) begin
        if (reset) begin
            tracking = 1'b0;
        end else begin
            if (!tracking && start_ack) begin
                tracking = 1'b1;
                pos_x = 0;
                pos_y = 0;
                // outputs still show the idle raster for LAT clocks
                for (int i = 0; i < LAT; i++) begin
                    exp_pix[i] = '0;
                    exp_sync[i] = idle_sync();
                    exp_x[i] = -1;
                    exp_y[i] = -1;
                end
            end
            if (tracking) begin
                if (exp_x[0] >= 0) begin
                    compare_addr(exp_x[0], exp_y[0]);
                end
                compare(exp_pix[LAT-1], exp_sync[LAT-1], exp_x[LAT-1], exp_y[LAT-1]);
                for (int i = LAT - 1; i > 0; i--) begin
                    exp_pix[i] = exp_pix[i-1];
                    exp_sync[i] = exp_sync[i-1];
                    exp_x[i] = exp_x[i-1];
                    exp_y[i] = exp_y[i-1];
                end
                predict(pos_x, pos_y, exp_pix[0], exp_sync[0]);
                exp_x[0] = pos_x;
                exp_y[0] = pos_y;
                if (pos_x == cfg.h_total - 1) begin
                    pos_x = 0;
                    pos_y = (pos_y == cfg.v_total - 1) ? 0 : pos_y + 1;
                end else begin
                    pos_x++;
                end
            end else begin
                compare('0, idle_sync(), -1, -1);
            end
        end
    end

endmodule

// ==== dv/video_tb.sv ====
`timescale 1ns/10ps
`include "video_params.svh"

module video_tb
    import video_pkg::*;
();

    localparam int ROWS = 3;
    localparam int FRAME_CYCLES = 800;
    // two frames per row, half again as margin
    localparam int TIMEOUT_CYCLES = ROWS * 2 * FRAME_CYCLES * 3 / 2;

    logic                     clock;
    logic                     reset;
    video_config_t            cfg;
    scanline_t                scan;
    logic                     start_req;
    pixel_t                   ram_data = '0;
    logic [7:0]               text_data = '0;
    logic                     start_ack;
    logic [`VIDEO_RAM_AW-1:0] ram_addr;
    logic [`TEXT_AW-1:0]      text_addr;
    pixel_t                   video_out;
    logic                     hsync;
    logic                     vsync;
    logic                     draw_area;

    video_config_t cfg_table [ROWS];
    scanline_t     scan_table [ROWS];
    int            cycles;
    int            other_errors;
    int            checks;
    int            mismatches;

    video_out_top dut0 (
        .clock     (clock),
        .reset     (reset),
        .cfg       (cfg),
        .scan      (scan),
        .start_req (start_req),
        .ram_data  (ram_data),
        .text_data (text_data),
        .start_ack (start_ack),
        .ram_addr  (ram_addr),
        .text_addr (text_addr),
        .video_out (video_out),
        .hsync     (hsync),
        .vsync     (vsync),
        .draw_area (draw_area)
    );

    video_monitor mon0 (
        .clock     (clock),
        .reset     (reset),
        .cfg       (cfg),
        .scan      (scan),
        .start_ack (start_ack),
        .ram_addr  (ram_addr),
        .text_addr (text_addr),
        .video_out (video_out),
        .hsync     (hsync),
        .vsync     (vsync),
        .draw_area (draw_area),
        .checks    (checks),
        .errors    (mismatches)
    );

    bind video_out_top video_checker chk0 (
        .clock     (clock),
        .reset     (reset),
        .cfg       (cfg),
        .start_req (start_req),
        .start_ack (start_ack),
        .hsync     (hsync),
        .vsync     (vsync)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #50 clock = ~clock;
        end
    end

    // frame ram model, one clock read latency
    always @(posedge clock) begin
        ram_data <= '{red: ram_addr[7:0], green: ram_addr[11:4], blue: ~ram_addr[7:0]};
    end

    // text ram holds its own address modulo 4
    always @(posedge clock) begin
        text_data <= 8'(text_addr % 4);
    end

    ////////////////////////////////////////////////////////////
    // configuration table, one row per repeat setting

    task automatic fill_table();
        cfg_table[0] = '{
            h_total: 40, h_visible: 32, h_sync_start: 34, h_sync_width: 4,
            v_total: 20, v_visible: 16, v_sync_start: 17, v_sync_width: 2,
            h_sync_pol: 1, v_sync_pol: 1, rep_h: 1, rep_v: 1, line_length: 32,
            osd_enable: 1, osd_bg_x_start: 4, osd_bg_x_end: 28, osd_bg_y_start: 0,
            osd_bg_y_end: 14, osd_text_x_start: 8, osd_text_y_start: 2,
            osd_text_x_end: 24, osd_text_y_end: 18, highlight_row: 1};
        scan_table[0] = '{active: 0, odd_even: 0, intensity: 8'h00};

        cfg_table[1] = '{
            h_total: 40, h_visible: 32, h_sync_start: 34, h_sync_width: 4,
            v_total: 20, v_visible: 16, v_sync_start: 17, v_sync_width: 2,
            h_sync_pol: 0, v_sync_pol: 1, rep_h: 2, rep_v: 2, line_length: 16,
            osd_enable: 1, osd_bg_x_start: 16, osd_bg_x_end: 32, osd_bg_y_start: 4,
            osd_bg_y_end: 12, osd_text_x_start: 0, osd_text_y_start: 8,
            osd_text_x_end: 16, osd_text_y_end: 16, highlight_row: 0};
        scan_table[1] = '{active: 1, odd_even: 1, intensity: 8'h80};

        // osd windows set but disabled
        cfg_table[2] = '{
            h_total: 40, h_visible: 32, h_sync_start: 33, h_sync_width: 5,
            v_total: 20, v_visible: 16, v_sync_start: 16, v_sync_width: 3,
            h_sync_pol: 0, v_sync_pol: 0, rep_h: 3, rep_v: 1, line_length: 11,
            osd_enable: 0, osd_bg_x_start: 2, osd_bg_x_end: 20, osd_bg_y_start: 2,
            osd_bg_y_end: 10, osd_text_x_start: 4, osd_text_y_start: 4,
            osd_text_x_end: 12, osd_text_y_end: 12, highlight_row: 0};
        scan_table[2] = '{active: 1, odd_even: 0, intensity: 8'hc0};
    endtask

    task automatic apply_reset(input int row);
        @(posedge clock);
        reset <= 1'b1;
        start_req <= 1'b0;
        cfg <= cfg_table[row];
        scan <= scan_table[row];
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        if (start_ack !== 1'b0) begin
            other_errors++;
            $display("start_ack is not low after reset in row %0d", row);
        end
    endtask

    task automatic start_raster();
        @(posedge clock);
        start_req <= 1'b1;
        do begin
            @(negedge clock);
        end while (start_ack !== 1'b1);
        @(posedge clock);
        start_req <= 1'b0;
        do begin
            @(negedge clock);
        end while (start_ack !== 1'b0);
    endtask

    initial begin
        fill_table();
        other_errors = 0;
        reset = 1'b1;
        cfg = cfg_table[0];
        scan = scan_table[0];
        start_req = 1'b0;

        for (int row = 0; row < ROWS; row++) begin
            apply_reset(row);
            start_raster();
            repeat (2 * int'(cfg_table[row].h_total) * int'(cfg_table[row].v_total)) begin
                @(posedge clock);
            end
        end

        @(negedge clock);
        $display("checks %0d, mismatches %0d, other errors %0d, assertion failures %0d",
            checks, mismatches, other_errors, dut0.chk0.assert_fails);
        if (mismatches == 0 && other_errors == 0 && dut0.chk0.assert_fails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout after %0d cycles, the run did not complete", cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== font.hex ====
// glyph rows, 4 glyphs of 8 rows, one byte per row
// address is glyph * 8 + row, msb is the leftmost pixel
ff
81
81
81
81
81
81
ff
18
24
42
42
7e
42
42
00
aa
55
aa
55
aa
55
aa
55
80
40
20
10
08
04
02
01

// ==== src.f ====
+incdir+include
verilog/video_pkg.sv
verilog/delay_line.sv
verilog/char_rom.sv
verilog/raster_timing.sv
verilog/pixel_mixer.sv
verilog/video_out_top.sv
dv/video_checker.sv
dv/video_monitor.sv
dv/video_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module video_tb -f src.f -o video_sim

# keep going past assertion errors so the testbench prints its summary
out=$(./obj_dir/video_sim +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED"
